// File: tb/debug_unit_vectors.txt
// One 32-bit hex word per line.
// @00 program words ending in the HALT word, @10 database words 0 to 11,
// @20 step commands until halt, @21 expected number of program writes.
@00
3c010010
34210004
2402ffff
8c220000
00431020
ac220008
ffffffff
@10
00000000
0000000a
fffffff6
12345678
9abcdef0
00ff00ff
ff00ff00
80000001
7fffffff
deadbeef
0badf00d
cafe1234
@20
00000003
00000006

// File: build.f
+incdir+include
rtl/debug_host_pkg.sv
rtl/debug_cpu_pkg.sv
rtl/debug_control_fsm.sv
rtl/program_loader.sv
rtl/register_dump_sender.sv
rtl/debug_unit.sv
tb/tb_debug_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the debug unit testbench, then look for the pass line.
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f build.f --top-module tb_debug_unit \
    && ./obj_dir/Vtb_debug_unit > sim.log 2>&1 \
    || echo "build or simulation failed" >> sim.log
cat sim.log
grep -q "Done: no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: include/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////////////////////////////////////////////
// Result checks against values taken from the vectors.
////////////////////////////////////////////////////////////

task automatic fail_check(input string what);
    $display("FAILED at %0t ns: %s", $time, what);
    $display("Done: errors found");
    $fatal(1, "Check failed.");
endtask

task automatic compare_byte(input string what, input host_byte_t got,
                            input host_byte_t exp);
    if (got !== exp) begin
        fail_check($sformatf("%s got 0x%02h, expected 0x%02h", what, got, exp));
    end
endtask

// Compared through the whole word view.
task automatic compare_word(input string what, input instr_word_u got,
                            input instr_word_u exp);
    if (got.word !== exp.word) begin
        fail_check($sformatf("%s got 0x%08h, expected 0x%08h", what, got.word, exp.word));
    end
endtask

task automatic compare_addr(input string what, input prog_addr_t got,
                            input prog_addr_t exp);
    if (got !== exp) begin
        fail_check($sformatf("%s got %0d, expected %0d", what, got, exp));
    end
endtask

task automatic compare_sel(input string what, input database_sel_t got,
                           input database_sel_t exp);
    if (got !== exp) begin
        fail_check($sformatf("%s got %0d, expected %0d", what, got, exp));
    end
endtask

`endif

// File: tb/tb_debug_unit.sv
`timescale 1ns/1ns

module tb_debug_unit
    import debug_host_pkg::*;
    import debug_cpu_pkg::*;
();

    localparam int wait_limit = 200; // Cycles allowed for any single wait.

    logic          i_clock;
    logic          i_reset;
    logic          i_rx_done;
    host_byte_t    i_rx_data;
    logic          i_soft_reset_ack = 1'b1;
    logic          i_flag_halt;
    instr_word_u   i_database_word  = '0;
    logic          o_tx_start;
    host_byte_t    o_tx_data;
    logic          o_soft_reset;
    logic          o_prog_write;
    prog_addr_t    o_prog_addr;
    instr_word_u   o_prog_data;
    logic          o_enable_pc;
    logic          o_enable_pipeline;
    database_sel_t o_database_sel;

    logic [31:0] vectors [0:63]; // Program at 0x00, database at 0x10, run data at 0x20.
    instr_word_u expected_write;
    int          prog_count;
    int          write_count = 0;
    int          low_cycles  = 0;
    integer      seed        = 32'h72779706;

    debug_unit i_dut (.*);

    `include "tb_checks.svh"

    initial i_clock = 1'b0;
    always #5 i_clock = ~i_clock;

    ////////////////////////////////////////////////////////////
    // Processor model
    ////////////////////////////////////////////////////////////

    always @(posedge i_clock) begin
        if (o_soft_reset === 1'b0) begin
            low_cycles <= low_cycles + 1;
        end else begin
            low_cycles <= 0;
        end
        // Ack goes low two cycles after the soft reset falls.
        i_soft_reset_ack     <= !((o_soft_reset === 1'b0) && (low_cycles >= 1));
        i_database_word.word <= vectors[16 + o_database_sel]; // Registered read.
    end

    // Every program write is checked against the next vector word.
    always @(negedge i_clock) begin
        if (o_prog_write === 1'b1) begin
            if (write_count >= prog_count) fail_check("program write beyond the last word");
            expected_write.word = vectors[write_count];
            compare_addr("program address", o_prog_addr, prog_addr_t'(write_count));
            compare_word("program data", o_prog_data, expected_write);
            write_count = write_count + 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Host side tasks
    ////////////////////////////////////////////////////////////

    // Done rises then falls, the DUT takes the byte before return.
    task automatic send_byte(input host_byte_t value);
        @(posedge i_clock);
        i_rx_data <= value;
        i_rx_done <= 1'b1;
        @(posedge i_clock);
        i_rx_done <= 1'b0;
        @(posedge i_clock);
    endtask

    task automatic send_word(input logic [31:0] word);
        for (int lane = 3; lane >= 0; lane--) begin
            send_byte(word[lane*8 +: 8]); // MSB first.
        end
    endtask

    task automatic wait_soft_reset_release();
        int cycles;
        cycles = 0;
        @(negedge i_clock);
        while (o_soft_reset !== 1'b1) begin
            cycles++;
            if (cycles > wait_limit) fail_check("timeout waiting for soft reset release");
            @(negedge i_clock);
        end
    endtask

    task automatic wait_dump_tx();
        int cycles;
        cycles = 0;
        @(negedge i_clock);
        while (o_tx_start !== 1'b1) begin
            cycles++;
            if (cycles > wait_limit) fail_check("timeout waiting for the register dump");
            @(negedge i_clock);
        end
    endtask

    // Soft reset, announce and program load.
    task automatic run_session();
        int word_index;
        send_byte(8'h00);
        @(negedge i_clock);
        if (o_soft_reset !== 1'b0) fail_check("soft reset not asserted after command");
        wait_soft_reset_release();
        if (i_soft_reset_ack !== 1'b0) fail_check("soft reset released before the ack");
        if (o_tx_start !== 1'b1) fail_check("announce byte not being sent");
        compare_byte("announce byte", o_tx_data, 8'h01);
        write_count = 0;
        for (word_index = 0; word_index < prog_count; word_index++) begin
            send_word(vectors[word_index]);
        end
        send_word(32'hffff_ffff);
        @(negedge i_clock);
        if (write_count != vectors[33]) fail_check("wrong number of program writes");
        if (o_enable_pc !== 1'b0) fail_check("execution enabled before a start command");
    endtask

    task automatic run_continuous(input int halt_after);
        int cycles;
        cycles = 0;
        send_byte(8'h03);
        @(negedge i_clock);
        while (o_enable_pc === 1'b1) begin
            cycles++;
            if (o_enable_pipeline !== 1'b1) fail_check("pipeline enable differs from PC enable");
            if (cycles > wait_limit) fail_check("timeout waiting for halt to end the run");
            if (cycles == halt_after - 1) begin
                @(posedge i_clock);
                i_flag_halt <= 1'b1; // Seen by the DUT in the next cycle.
            end
            @(negedge i_clock);
        end
        if (cycles != halt_after) fail_check("continuous run length does not match halt");
        if (o_enable_pipeline !== 1'b0) fail_check("pipeline enable stuck after halt");
    endtask

    task automatic run_step(input logic halt_now);
        @(posedge i_clock);
        i_flag_halt <= halt_now;
        send_byte(8'h07);
        @(negedge i_clock);
        if ((o_enable_pc !== 1'b1) || (o_enable_pipeline !== 1'b1)) begin
            fail_check("step command did not enable execution");
        end
        @(negedge i_clock);
        if ((o_enable_pc !== 1'b0) || (o_enable_pipeline !== 1'b0)) begin
            fail_check("step enabled execution for more than one cycle");
        end
    endtask

    task automatic check_dump();
        logic [31:0] word;
        wait_dump_tx();
        for (int w = 0; w < 12; w++) begin
            word = vectors[16 + w];
            for (int lane = 3; lane >= 0; lane--) begin
                @(posedge i_clock); // Database read lags the select.
                @(negedge i_clock);
                if (o_tx_start !== 1'b1) fail_check("transmit dropped during the dump");
                compare_sel("database select", o_database_sel, database_sel_t'(w));
                compare_byte("dump byte", o_tx_data, word[lane*8 +: 8]);
                if (lane == 3) begin
                    send_byte(8'h20); // Lane 0 ack, wrong for lane 3.
                    @(negedge i_clock);
                    compare_byte("dump byte after wrong ack", o_tx_data, word[lane*8 +: 8]);
                end
                send_byte(host_byte_t'(8 * (4 - lane)));
            end
        end
        @(negedge i_clock);
        if (o_tx_start !== 1'b0) fail_check("transmit still active after the dump");
    endtask

    ////////////////////////////////////////////////////////////
    // Scenario
    ////////////////////////////////////////////////////////////

    initial begin
        int steps;
        i_reset     <= 1'b0;
        i_rx_done   <= 1'b0;
        i_rx_data   <= '0;
        i_flag_halt <= 1'b0;
        $readmemh("tb/debug_unit_vectors.txt", vectors);
        prog_count = 0;
        while ((prog_count < 16) && (vectors[prog_count] !== 32'hffff_ffff)) begin
            prog_count++;
        end
        steps = vectors[32];

        repeat (10) @(posedge i_clock);
        i_reset <= 1'b1;
        @(negedge i_clock);
        if ((o_tx_start !== 1'b0) || (o_prog_write !== 1'b0) || (o_enable_pc !== 1'b0)
            || (o_enable_pipeline !== 1'b0) || (o_soft_reset !== 1'b1)) begin
            fail_check("outputs not in their reset state");
        end

        run_session();
        run_continuous(2 + ({$random(seed)} % 14));
        check_dump();

        // Back in idle, so a new soft reset is taken.
        @(posedge i_clock);
        i_flag_halt <= 1'b0;
        run_session();
        for (int s = 1; s <= steps; s++) begin
            run_step(s == steps); // Halt only on the last step.
            check_dump();
        end

        @(posedge i_clock);
        i_flag_halt <= 1'b0;
        run_session(); // A step that saw halt also ends in idle.

        $display("Done: no errors");
        $finish;
    end

endmodule

// File: rtl/debug_unit.sv
`timescale 1ns/1ns

module debug_unit
    import debug_host_pkg::*;
    import debug_cpu_pkg::*;
(
    input  logic          i_clock,
    input  logic          i_reset,
    input  logic          i_rx_done,
    input  host_byte_t    i_rx_data,
    input  logic          i_soft_reset_ack,
    input  logic          i_flag_halt,
    input  instr_word_u   i_database_word,
    output logic          o_tx_start,
    output host_byte_t    o_tx_data,
    output logic          o_soft_reset,
    output logic          o_prog_write,
    output prog_addr_t    o_prog_addr,
    output instr_word_u   o_prog_data,
    output logic          o_enable_pc,
    output logic          o_enable_pipeline,
    output database_sel_t o_database_sel
);

    logic       byte_strobe;
    host_byte_t rx_byte;
    logic       load_active;
    logic       load_done;
    logic       dump_start;
    host_byte_t dump_byte;
    logic       dump_busy;
    logic       dump_done;

    debug_control_fsm u_control (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_rx_done        (i_rx_done),
        .i_rx_data        (i_rx_data),
        .i_soft_reset_ack (i_soft_reset_ack),
        .i_flag_halt      (i_flag_halt),
        .i_load_done      (load_done),
        .i_dump_byte      (dump_byte),
        .i_dump_busy      (dump_busy),
        .i_dump_done      (dump_done),
        .o_byte_strobe    (byte_strobe),
        .o_rx_byte        (rx_byte),
        .o_load_active    (load_active),
        .o_dump_start     (dump_start),
        .o_tx_start       (o_tx_start),
        .o_tx_data        (o_tx_data),
        .o_soft_reset     (o_soft_reset),
        .o_enable_pc      (o_enable_pc),
        .o_enable_pipeline(o_enable_pipeline)
    );

    program_loader u_loader (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_load_active(load_active),
        .i_byte_strobe(byte_strobe),
        .i_rx_byte    (rx_byte),
        .o_prog_write (o_prog_write),
        .o_prog_addr  (o_prog_addr),
        .o_prog_data  (o_prog_data),
        .o_load_done  (load_done)
    );

    register_dump_sender u_dump (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_dump_start   (dump_start),
        .i_byte_strobe  (byte_strobe),
        .i_rx_byte      (rx_byte),
        .i_database_word(i_database_word),
        .o_database_sel (o_database_sel),
        .o_dump_byte    (dump_byte),
        .o_dump_busy    (dump_busy),
        .o_dump_done    (dump_done)
    );

endmodule

// File: rtl/register_dump_sender.sv
`timescale 1ns/1ns

module register_dump_sender
    import debug_host_pkg::*;
    import debug_cpu_pkg::*;
(
    input  logic          i_clock,
    input  logic          i_reset,
    input  logic          i_dump_start,
    input  logic          i_byte_strobe,
    input  host_byte_t    i_rx_byte,
    input  instr_word_u   i_database_word,
    output database_sel_t o_database_sel,
    output host_byte_t    o_dump_byte,
    output logic          o_dump_busy,
    output logic          o_dump_done
);

    localparam lane_index_t first_lane = lane_index_t'(lanes_per_word - 1);
    localparam database_sel_t last_word_index = database_sel_t'(database_words - 1);

    database_sel_t word_index;
    lane_index_t   lane;
    logic          ack_match;
    logic          last_lane;
    logic          last_word;

    // Each lane has its own acknowledge, anything else is ignored.
    assign ack_match = o_dump_busy && i_byte_strobe && (i_rx_byte == dump_ack_bytes[lane]);
    assign last_lane = (lane == '0);
    assign last_word = (word_index == last_word_index);

    ////////////////////////////////////////////////////////////
    // Word and lane walk
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            word_index  <= '0;
            lane        <= first_lane;
            o_dump_busy <= 1'b0;
            o_dump_done <= 1'b0;
        end else begin
            o_dump_done <= ack_match && last_lane && last_word;

            if (i_dump_start) begin
                word_index  <= '0;
                lane        <= first_lane; // MSB goes out first.
                o_dump_busy <= 1'b1;
            end else if (ack_match) begin
                if (!last_lane) begin
                    lane <= lane - 1'b1;
                end else if (!last_word) begin
                    word_index <= word_index + 1'b1;
                    lane       <= first_lane;
                end else begin
                    o_dump_busy <= 1'b0; // Whole database sent.
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Byte selection
    ////////////////////////////////////////////////////////////

    assign o_database_sel = word_index;
    assign o_dump_byte    = i_database_word.bytes[lane]; // Current lane of the word.

endmodule

// File: rtl/program_loader.sv
`timescale 1ns/1ns

module program_loader
    import debug_host_pkg::*;
    import debug_cpu_pkg::*;
(
    input  logic        i_clock,
    input  logic        i_reset,
    input  logic        i_load_active,
    input  logic        i_byte_strobe,
    input  host_byte_t  i_rx_byte,
    output logic        o_prog_write,
    output prog_addr_t  o_prog_addr,
    output instr_word_u o_prog_data,
    output logic        o_load_done
);

    instr_word_u shift_word; // Bytes gathered so far.
    instr_word_u next_word;
    lane_index_t byte_count;
    logic        byte_taken;
    logic        word_complete;

    // Most significant byte arrives first, so shift towards lane 3.
    always_comb begin
        next_word.bytes = {shift_word.bytes[lanes_per_word-2:0], i_rx_byte};
    end

    assign byte_taken    = i_load_active && i_byte_strobe;
    assign word_complete = byte_taken && (byte_count == lane_index_t'(lanes_per_word - 1));

    ////////////////////////////////////////////////////////////
    // Counters and strobes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            byte_count   <= '0;
            o_prog_addr  <= '0;
            o_prog_write <= 1'b0;
            o_load_done  <= 1'b0;
        end else begin
            o_prog_write <= word_complete && (next_word.word != halt_instruction);
            o_load_done  <= word_complete && (next_word.word == halt_instruction);

            if (!i_load_active) begin
                byte_count  <= '0;
                o_prog_addr <= '0;
            end else begin
                if (i_byte_strobe) begin
                    byte_count <= byte_count + 1'b1; // Wraps after lane 0.
                end
                if (o_prog_write) begin
                    o_prog_addr <= o_prog_addr + 1'b1; // Next slot after a write.
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Instruction data
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (byte_taken) begin
            shift_word <= next_word;
        end
        if (word_complete) begin
            o_prog_data <= next_word; // Valid with the write strobe.
        end
    end

endmodule

// File: rtl/debug_control_fsm.sv
`timescale 1ns/1ns

module debug_control_fsm
    import debug_host_pkg::*;
(
    input  logic       i_clock,
    input  logic       i_reset,
    input  logic       i_rx_done,
    input  host_byte_t i_rx_data,
    input  logic       i_soft_reset_ack,
    input  logic       i_flag_halt,
    input  logic       i_load_done,
    input  host_byte_t i_dump_byte,
    input  logic       i_dump_busy,
    input  logic       i_dump_done,
    output logic       o_byte_strobe,
    output host_byte_t o_rx_byte,
    output logic       o_load_active,
    output logic       o_dump_start,
    output logic       o_tx_start,
    output host_byte_t o_tx_data,
    output logic       o_soft_reset,
    output logic       o_enable_pc,
    output logic       o_enable_pipeline
);

    logic [state_width-1:0] state;
    logic [state_width-1:0] next_state;

    logic rx_done_q;    // Receiver done, one cycle late.
    logic byte_strobe;
    logic start_cmd;
    logic run_ends;
    logic mode_step;    // Zero for continuous.
    logic halt_seen;
    logic dump_start_q;

    ////////////////////////////////////////////////////////////
    // Receive strobe
    ////////////////////////////////////////////////////////////

    // A byte is taken on the falling edge of the done flag.
    assign byte_strobe   = ~i_rx_done & rx_done_q;
    assign o_byte_strobe = byte_strobe;
    assign o_rx_byte     = i_rx_data; // Sampled only while strobed.

    assign start_cmd = byte_strobe &&
                       ((i_rx_data == cmd_run_continuous) || (i_rx_data == cmd_run_step));

    // Step runs a single clock, continuous runs until halt.
    assign run_ends = mode_step || i_flag_halt;

    ////////////////////////////////////////////////////////////
    // State and session flags
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state        <= st_idle;
            rx_done_q    <= 1'b0;
            mode_step    <= 1'b0;
            halt_seen    <= 1'b0;
            dump_start_q <= 1'b0;
        end else begin
            state        <= next_state;
            rx_done_q    <= i_rx_done;
            dump_start_q <= (state == st_run) && run_ends; // Cycle after the last enable.

            if ((state == st_wait_start) && start_cmd) begin
                mode_step <= i_rx_data[step_mode_bit];
            end

            if (state == st_idle) begin
                halt_seen <= 1'b0;
            end else if ((state == st_run) && i_flag_halt) begin
                halt_seen <= 1'b1; // Kept through the dump.
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (byte_strobe && (i_rx_data == cmd_soft_reset)) begin
                    next_state = st_soft_reset;
                end
            end
            st_soft_reset: begin
                if (!i_soft_reset_ack) begin // Processor ack is active low.
                    next_state = st_announce;
                end
            end
            st_announce: begin
                if (byte_strobe) begin // First program byte.
                    next_state = st_load;
                end
            end
            st_load: begin
                if (i_load_done) begin
                    next_state = st_wait_start;
                end
            end
            st_wait_start: begin
                if (start_cmd) begin
                    next_state = st_run;
                end
            end
            st_run: begin
                if (run_ends) begin
                    next_state = st_dump;
                end
            end
            st_dump: begin
                if (i_dump_done) begin
                    // Only a clean step may be followed by another start.
                    next_state = (mode_step && !halt_seen) ? st_wait_start : st_idle;
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////

    // The loader listens from announce on, so the byte that ends
    // the announce phase lands in the first instruction.
    assign o_load_active = (state == st_announce) || (state == st_load);
    assign o_dump_start  = dump_start_q;

    assign o_soft_reset      = (state != st_soft_reset); // Active low.
    assign o_enable_pc       = (state == st_run);
    assign o_enable_pipeline = (state == st_run);

    always_comb begin
        o_tx_start = 1'b0;
        o_tx_data  = '0;
        if (state == st_announce) begin
            o_tx_start = 1'b1;
            o_tx_data  = announce_byte;
        end else if ((state == st_dump) && i_dump_busy) begin
            o_tx_start = 1'b1;
            o_tx_data  = i_dump_byte; // Held until the host acknowledges.
        end
    end

endmodule

// File: rtl/debug_cpu_pkg.sv
package debug_cpu_pkg;

    import debug_host_pkg::*;

    ////////////////////////////////////////////////////////////
    // Program memory side.
    ////////////////////////////////////////////////////////////
    localparam int instr_width     = 32;
    localparam int prog_addr_width = 10; // 1K instruction words.

    localparam logic [instr_width-1:0] halt_instruction = '1;

    typedef logic [prog_addr_width-1:0] prog_addr_t;

    ////////////////////////////////////////////////////////////
    // Register database read back after execution.
    ////////////////////////////////////////////////////////////
    localparam int database_words = 12;

    typedef logic [$clog2(database_words)-1:0] database_sel_t;

    // One instruction or register word. The loader shifts host bytes in
    // through the byte view and compares the whole word against HALT;
    // the dump sender picks one byte lane at a time.
    typedef union packed {
        logic [instr_width-1:0]          word;  // Whole instruction.
        host_byte_t [lanes_per_word-1:0] bytes; // Lane 3 is the MSB.
    } instr_word_u;

endpackage

// File: rtl/debug_host_pkg.sv
package debug_host_pkg;

    ////////////////////////////////////////////////////////////
    // Byte format seen on the serial link.
    ////////////////////////////////////////////////////////////
    localparam int host_byte_width = 8;
    typedef logic [host_byte_width-1:0] host_byte_t;

    localparam host_byte_t cmd_soft_reset     = 8'h00; // Starts a new session.
    localparam host_byte_t announce_byte      = 8'h01; // Sent once reset is acknowledged.
    localparam host_byte_t cmd_run_continuous = 8'h03;
    localparam host_byte_t cmd_run_step       = 8'h07;
    localparam int         step_mode_bit      = 2;     // Set only in the step command.

    ////////////////////////////////////////////////////////////
    // Dump lanes, index 3 is the most significant byte.
    ////////////////////////////////////////////////////////////
    localparam int lanes_per_word = 4;
    typedef logic [$clog2(lanes_per_word)-1:0] lane_index_t;

    localparam host_byte_t [lanes_per_word-1:0] dump_ack_bytes = {8'h08, 8'h10, 8'h18, 8'h20};

    // Session phases of the control FSM.
    localparam int state_width = 3;
    localparam logic [state_width-1:0] st_idle       = 3'd0;
    localparam logic [state_width-1:0] st_soft_reset = 3'd1;
    localparam logic [state_width-1:0] st_announce   = 3'd2;
    localparam logic [state_width-1:0] st_load       = 3'd3;
    localparam logic [state_width-1:0] st_wait_start = 3'd4;
    localparam logic [state_width-1:0] st_run        = 3'd5;
    localparam logic [state_width-1:0] st_dump       = 3'd6;

endpackage
